//--- verilog/cpu6502_pkg.sv
package cpu6502_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  cycle_t;

    // Sources for the internal data bus
    typedef enum logic [2:0] {
        BUS_DL,
        BUS_AC,
        BUS_X,
        BUS_Y,
        BUS_ALU,
        BUS_PCL,
        BUS_PCH,
        BUS_P
    } bus_src_e;

    typedef enum logic [2:0] {
        ALU_SUM,
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_PASS
    } alu_op_e;

    // Instruction cycles
    localparam cycle_t T0 = 3'd0;
    localparam cycle_t T1 = 3'd1;
    localparam cycle_t T2 = 3'd2;
    localparam cycle_t T3 = 3'd3;

    localparam data_t OP_LDA_IMM = 8'hA9;
    localparam data_t OP_LDX_IMM = 8'hA2;
    localparam data_t OP_LDY_IMM = 8'hA0;
    localparam data_t OP_LDA_ABS = 8'hAD;
    localparam data_t OP_STA_ABS = 8'h8D;
    localparam data_t OP_ADC_IMM = 8'h69;
    localparam data_t OP_AND_IMM = 8'h29;
    localparam data_t OP_ORA_IMM = 8'h09;
    localparam data_t OP_EOR_IMM = 8'h49;
    localparam data_t OP_TAX     = 8'hAA;
    localparam data_t OP_TAY     = 8'hA8;
    localparam data_t OP_TXA     = 8'h8A;
    localparam data_t OP_INX     = 8'hE8;
    localparam data_t OP_JMP_ABS = 8'h4C;
    localparam data_t OP_CLC     = 8'h18;
    localparam data_t OP_SEC     = 8'h38;
    localparam data_t OP_NOP     = 8'hEA;

    // Status register bit positions
    localparam int P_C = 0;
    localparam int P_Z = 1;
    localparam int P_V = 6;
    localparam int P_N = 7;

endpackage

//--- verilog/cpu_ctrl_if.sv
`timescale 1ns/1ps

interface cpu_ctrl_if
    import cpu6502_pkg::*;
();

    // Internal data bus source
    bus_src_e db_src;

    // Register destinations, taken with the ALU operation
    logic     ld_ac;
    logic     ld_x;
    logic     ld_y;

    alu_op_e  alu_op;
    logic     alu_carry_in_sel;
    logic     alu_b_one;
    logic     ld_alu;

    // Program counter and address selection
    logic     pc_inc;
    logic     pc_load_dl_hi;
    logic     adl_from_pc;
    logic     addr_from_dl;
    logic     ld_dl_lo;

    logic     write_en;

    // Status updates
    logic     upd_nz;
    logic     upd_c;
    logic     set_c_val;

    modport decoder (
        output db_src, ld_ac, ld_x, ld_y,
        output alu_op, alu_carry_in_sel, alu_b_one, ld_alu,
        output pc_inc, pc_load_dl_hi, adl_from_pc, addr_from_dl, ld_dl_lo,
        output write_en, upd_nz, upd_c, set_c_val
    );

    modport datapath (
        input db_src, ld_ac, ld_x, ld_y,
        input alu_op, alu_carry_in_sel, alu_b_one, ld_alu,
        input pc_inc, pc_load_dl_hi, adl_from_pc, addr_from_dl, ld_dl_lo,
        input write_en, upd_nz, upd_c, set_c_val
    );

endinterface

//--- verilog/timing_control.sv
`timescale 1ns/1ps

module timing_control
    import cpu6502_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  data_t  i_data,
    input  logic   i_last,
    output cycle_t o_cycle,
    output data_t  o_ir,
    output logic   o_sync
);

    cycle_t cycle_q;
    data_t  ir_q;

    // Cycle counter, back to T0 after the last cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cycle_q <= T0;
        end else if (i_last) begin
            cycle_q <= T0;
        end else begin
            cycle_q <= cycle_q + cycle_t'(1);
        end
    end

    // Opcode arrives in T1, one cycle after the fetch address
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ir_q <= OP_NOP;
        end else if (cycle_q == T1) begin
            ir_q <= i_data;
        end
    end

    // In T1 the decoder sees the new opcode straight from the bus
    assign o_ir = (cycle_q == T1) ? i_data : ir_q;

    assign o_cycle = cycle_q;
    assign o_sync  = (cycle_q == T0);

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder
    import cpu6502_pkg::*;
(
    input  data_t              i_ir,
    input  cycle_t             i_cycle,
    output logic               o_last,
    cpu_ctrl_if.decoder        ctrl
);

    always_comb begin
        ctrl.db_src           = BUS_DL;
        ctrl.ld_ac            = 1'b0;
        ctrl.ld_x             = 1'b0;
        ctrl.ld_y             = 1'b0;
        ctrl.alu_op           = ALU_PASS;
        ctrl.alu_carry_in_sel = 1'b0;
        ctrl.alu_b_one        = 1'b0;
        ctrl.ld_alu           = 1'b0;
        ctrl.pc_inc           = 1'b0;
        ctrl.pc_load_dl_hi    = 1'b0;
        ctrl.adl_from_pc      = 1'b0;
        ctrl.addr_from_dl     = 1'b0;
        ctrl.ld_dl_lo         = 1'b0;
        ctrl.write_en         = 1'b0;
        ctrl.upd_nz           = 1'b0;
        ctrl.upd_c            = 1'b0;
        ctrl.set_c_val        = 1'b0;
        o_last                = 1'b0;

        case (i_cycle)
            T0: begin
                // Opcode fetch; JMP target high byte is arriving right now
                ctrl.pc_inc = 1'b1;
                if (i_ir == OP_JMP_ABS) begin
                    ctrl.addr_from_dl  = 1'b1;
                    ctrl.pc_load_dl_hi = 1'b1;
                end else begin
                    ctrl.adl_from_pc = 1'b1;
                end

                // Execute of the previous instruction, i_ir still holds it
                case (i_ir)
                    OP_LDA_IMM, OP_LDA_ABS: begin
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_ac  = 1'b1;
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_LDX_IMM: begin
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_x   = 1'b1;
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_LDY_IMM: begin
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_y   = 1'b1;
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_ADC_IMM: begin
                        ctrl.alu_op           = ALU_SUM;
                        ctrl.alu_carry_in_sel = 1'b1;
                        ctrl.ld_alu           = 1'b1;
                        ctrl.ld_ac            = 1'b1;
                        ctrl.upd_nz           = 1'b1;
                        ctrl.upd_c            = 1'b1;
                    end
                    OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                        if (i_ir == OP_AND_IMM) begin
                            ctrl.alu_op = ALU_AND;
                        end else if (i_ir == OP_ORA_IMM) begin
                            ctrl.alu_op = ALU_OR;
                        end else begin
                            ctrl.alu_op = ALU_EOR;
                        end
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_ac  = 1'b1;
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_TAX, OP_TAY: begin
                        ctrl.db_src = BUS_AC;
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_x   = (i_ir == OP_TAX);
                        ctrl.ld_y   = (i_ir == OP_TAY);
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_TXA: begin
                        ctrl.db_src = BUS_X;
                        ctrl.ld_alu = 1'b1;
                        ctrl.ld_ac  = 1'b1;
                        ctrl.upd_nz = 1'b1;
                    end
                    OP_INX: begin
                        // X + 1 with carry in forced to zero
                        ctrl.db_src    = BUS_X;
                        ctrl.alu_op    = ALU_SUM;
                        ctrl.alu_b_one = 1'b1;
                        ctrl.ld_alu    = 1'b1;
                        ctrl.ld_x      = 1'b1;
                        ctrl.upd_nz    = 1'b1;
                    end
                    OP_CLC, OP_SEC: begin
                        ctrl.set_c_val = (i_ir == OP_SEC);
                        ctrl.ld_alu    = 1'b1;
                        ctrl.upd_c     = 1'b1;
                    end
                    default: ;
                endcase
            end
            T1: begin
                ctrl.adl_from_pc = 1'b1;
                case (i_ir)
                    OP_JMP_ABS, OP_LDA_ABS, OP_STA_ABS: begin
                        ctrl.pc_inc = 1'b1;
                    end
                    OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM,
                    OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                        ctrl.pc_inc = 1'b1;
                        o_last      = 1'b1;
                    end
                    // Implied and unknown opcodes, dummy read without increment
                    default: o_last = 1'b1;
                endcase
            end
            T2: begin
                // High address byte out, low byte arriving
                ctrl.adl_from_pc = 1'b1;
                ctrl.pc_inc      = 1'b1;
                ctrl.ld_dl_lo    = 1'b1;
                o_last           = (i_ir == OP_JMP_ABS);
            end
            T3: begin
                ctrl.addr_from_dl = 1'b1;
                if (i_ir == OP_STA_ABS) begin
                    ctrl.db_src   = BUS_AC;
                    ctrl.write_en = 1'b1;
                end
                o_last = 1'b1;
            end
            default: o_last = 1'b1;
        endcase
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
    import cpu6502_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  data_t   i_a,
    input  data_t   i_b,
    input  alu_op_e i_op,
    input  logic    i_carry,
    output data_t   o_result,
    output logic    o_carry_out
);

    data_t result;
    logic  carry;

    always_comb begin
        // Logic ops and pass leave the carry as it came in
        carry = i_carry;
        case (i_op)
            ALU_SUM: {carry, result} = {1'b0, i_a} + {1'b0, i_b} + {8'b0, i_carry};
            ALU_AND: result = i_a & i_b;
            ALU_OR:  result = i_a | i_b;
            ALU_EOR: result = i_a ^ i_b;
            default: result = i_a;
        endcase
    end

    // Adder hold register, read in the following cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result    <= '0;
            o_carry_out <= 1'b0;
        end else begin
            o_result    <= result;
            o_carry_out <= carry;
        end
    end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath
    import cpu6502_pkg::*;
#(
    parameter addr_t RESET_PC = 16'h0200
) (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  data_t         i_data,
    cpu_ctrl_if.datapath  ctrl,
    output addr_t         o_address,
    output data_t         o_data,
    output logic          o_rw,
    output data_t         o_dbg_ac,
    output data_t         o_dbg_x,
    output data_t         o_dbg_y,
    output data_t         o_dbg_p,
    output addr_t         o_dbg_pc
);

    data_t ac_q;
    data_t x_q;
    data_t y_q;
    data_t p_q;
    addr_t pc_q;
    addr_t ab_q;
    data_t dl_lo_q;
    data_t db;
    addr_t dl_addr;
    addr_t pc_base;
    data_t alu_b;
    logic  alu_carry_in;
    data_t alu_result;
    logic  alu_carry_out;
    logic  wb_ac_q;
    logic  wb_x_q;
    logic  wb_y_q;
    logic  wb_nz_q;
    logic  wb_c_q;
    logic  wb_v_q;
    logic  a7_q;
    logic  b7_q;

    // Internal data bus; DL is the memory data of this cycle
    always_comb begin
        case (ctrl.db_src)
            BUS_DL:  db = i_data;
            BUS_AC:  db = ac_q;
            BUS_X:   db = x_q;
            BUS_Y:   db = y_q;
            BUS_ALU: db = alu_result;
            BUS_PCL: db = pc_q[7:0];
            BUS_PCH: db = pc_q[15:8];
            BUS_P:   db = p_q;
        endcase
    end

    assign dl_addr = {i_data, dl_lo_q};

    always_comb begin
        if (ctrl.addr_from_dl) begin
            o_address = dl_addr;
        end else if (ctrl.adl_from_pc) begin
            o_address = pc_q;
        end else begin
            o_address = ab_q;
        end
    end

    assign pc_base = ctrl.pc_load_dl_hi ? dl_addr : pc_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
            ab_q <= RESET_PC;
        end else begin
            pc_q <= pc_base + addr_t'(ctrl.pc_inc);
            ab_q <= o_address;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ctrl.ld_dl_lo) begin
            dl_lo_q <= i_data;
        end
    end

    // Bus value on input A, AC or constant one on input B
    assign alu_b        = ctrl.alu_b_one ? 8'h01 : ac_q;
    assign alu_carry_in = ctrl.alu_carry_in_sel ? p_q[P_C] : ctrl.set_c_val;

    alu alu_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_a         (db),
        .i_b         (alu_b),
        .i_op        (ctrl.alu_op),
        .i_carry     (alu_carry_in),
        .o_result    (alu_result),
        .o_carry_out (alu_carry_out)
    );

    // Destinations follow the ALU result by one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_ac_q <= 1'b0;
            wb_x_q  <= 1'b0;
            wb_y_q  <= 1'b0;
            wb_nz_q <= 1'b0;
            wb_c_q  <= 1'b0;
            wb_v_q  <= 1'b0;
        end else begin
            wb_ac_q <= ctrl.ld_alu & ctrl.ld_ac;
            wb_x_q  <= ctrl.ld_alu & ctrl.ld_x;
            wb_y_q  <= ctrl.ld_alu & ctrl.ld_y;
            wb_nz_q <= ctrl.ld_alu & ctrl.upd_nz;
            wb_c_q  <= ctrl.ld_alu & ctrl.upd_c;
            wb_v_q  <= ctrl.ld_alu & ctrl.upd_c & (ctrl.alu_op == ALU_SUM);
        end
    end

    // Operand signs for overflow
    always_ff @(posedge i_clk) begin
        a7_q <= db[7];
        b7_q <= alu_b[7];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ac_q <= '0;
            x_q  <= '0;
            y_q  <= '0;
            p_q  <= '0;
        end else begin
            if (wb_ac_q) begin
                ac_q <= alu_result;
            end
            if (wb_x_q) begin
                x_q <= alu_result;
            end
            if (wb_y_q) begin
                y_q <= alu_result;
            end
            if (wb_nz_q) begin
                p_q[P_N] <= alu_result[7];
                p_q[P_Z] <= (alu_result == '0);
            end
            if (wb_c_q) begin
                p_q[P_C] <= alu_carry_out;
            end
            if (wb_v_q) begin
                p_q[P_V] <= (a7_q == b7_q) && (alu_result[7] != a7_q);
            end
        end
    end

    assign o_data = db;
    assign o_rw   = ~ctrl.write_en;

    assign o_dbg_ac = ac_q;
    assign o_dbg_x  = x_q;
    assign o_dbg_y  = y_q;
    assign o_dbg_p  = p_q;
    assign o_dbg_pc = pc_q;

endmodule

//--- verilog/cpu6502.sv
`timescale 1ns/1ps

module cpu6502
    import cpu6502_pkg::*;
#(
    parameter addr_t RESET_PC = 16'h0200
) (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  data_t i_data,
    output addr_t o_address,
    output data_t o_data,
    output logic  o_rw,        // 1 = read, 0 = write
    output logic  o_sync,      // High in the opcode fetch cycle
    output data_t o_dbg_ac,
    output data_t o_dbg_x,
    output data_t o_dbg_y,
    output data_t o_dbg_p,
    output addr_t o_dbg_pc
);

    cycle_t cycle;
    data_t  ir;
    logic   last;

    cpu_ctrl_if ctrl_if ();

    timing_control timing_control_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_data),
        .i_last  (last),
        .o_cycle (cycle),
        .o_ir    (ir),
        .o_sync  (o_sync)
    );

    decoder decoder_inst (
        .i_ir    (ir),
        .i_cycle (cycle),
        .o_last  (last),
        .ctrl    (ctrl_if.decoder)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) datapath_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .ctrl      (ctrl_if.datapath),
        .o_address (o_address),
        .o_data    (o_data),
        .o_rw      (o_rw),
        .o_dbg_ac  (o_dbg_ac),
        .o_dbg_x   (o_dbg_x),
        .o_dbg_y   (o_dbg_y),
        .o_dbg_p   (o_dbg_p),
        .o_dbg_pc  (o_dbg_pc)
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic o_clk
);

    // Free running, starts low
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

//--- dv/cpu6502_sva.sv
`timescale 1ns/1ps

module cpu6502_sva (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_sync,
    input logic i_rw
);

    // Every instruction is at least two cycles long
    sync_single_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_sync |=> !i_sync
    ) else $error("o_sync stayed high for more than one cycle");

    no_write_in_fetch: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_sync && !i_rw)
    ) else $error("write cycle during an opcode fetch");

    // Only the T3 of STA writes
    write_only_in_t3: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_rw |-> ($past(i_sync, 3) && !$past(i_sync, 2) && !$past(i_sync, 1))
    ) else $error("write cycle outside the fourth cycle of an instruction");

endmodule

bind cpu6502 cpu6502_sva cpu6502_sva_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_sync  (o_sync),
    .i_rw    (o_rw)
);

//--- dv/cpu6502_tb.sv
`timescale 1ns/1ps

module cpu6502_tb
    import cpu6502_pkg::*;
();

    localparam addr_t RESET_PC        = 16'h0200;
    localparam int    CLK_PERIOD      = 10;
    // Upper bound on the program run in cycles
    localparam int    PROGRAM_CYCLES  = 500;
    localparam int    WATCHDOG_CYCLES = 4 * PROGRAM_CYCLES;
    // Trace records hold fetch address lo and hi, then AC X Y P after the previous instruction
    localparam addr_t TRACE_BASE      = 16'hFF00;
    localparam int    RECORD_BYTES    = 6;
    localparam addr_t SUMMARY_BASE    = 16'hFFF0;

    logic  i_clk;
    logic  i_rst_n;
    data_t i_data = 8'h00;
    addr_t o_address;
    data_t o_data;
    logic  o_rw;
    logic  o_sync;
    data_t o_dbg_ac;
    data_t o_dbg_x;
    data_t o_dbg_y;
    data_t o_dbg_p;
    addr_t o_dbg_pc;

    data_t mem [0:65535];
    int    errors;
    int    checks;
    int    writes;
    addr_t store_addr;
    data_t store_val;
    addr_t halt_addr;
    int    n_records;

    tb_clock #(
        .PERIOD_NS (CLK_PERIOD)
    ) tb_clock_inst (
        .o_clk (i_clk)
    );

    cpu6502 #(
        .RESET_PC (RESET_PC)
    ) cpu6502_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .o_address (o_address),
        .o_data    (o_data),
        .o_rw      (o_rw),
        .o_sync    (o_sync),
        .o_dbg_ac  (o_dbg_ac),
        .o_dbg_x   (o_dbg_x),
        .o_dbg_y   (o_dbg_y),
        .o_dbg_p   (o_dbg_p),
        .o_dbg_pc  (o_dbg_pc)
    );

    // Synchronous memory with read data valid in the cycle after the address
    always @(posedge i_clk) begin
        if (o_rw) begin
            i_data <= mem[o_address];
        end else begin
            mem[o_address] <= o_data;
        end
    end

    task automatic check_byte(input string what, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Checks: %0d, errors: %0d, write cycles: %0d", checks, errors, writes);
    endtask

    // Pattern mixes both address bytes
    task automatic fill_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[addr_t'(a)] = a[15:8] ^ a[7:0];
        end
    endtask

    // Only STA drives a write; one expected over the whole program
    always @(negedge i_clk) begin
        if (i_rst_n && o_rw === 1'b0) begin
            writes++;
            check_addr("store address", o_address, store_addr);
            check_byte("store data", o_data, store_val);
        end
    end

    initial begin
        addr_t rec;
        addr_t fetch;

        i_rst_n = 1'b0;
        errors  = 0;
        checks  = 0;
        writes  = 0;
        fetch   = '0;
        fill_memory();
        $readmemh("dv/cpu6502_vectors.hex", mem);
        store_addr = {mem[SUMMARY_BASE + 16'd5], mem[SUMMARY_BASE + 16'd4]};
        store_val  = mem[SUMMARY_BASE + 16'd6];
        halt_addr  = {mem[SUMMARY_BASE + 16'd8], mem[SUMMARY_BASE + 16'd7]};
        n_records  = int'(mem[SUMMARY_BASE + 16'd9]);

        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);

        // First cycle after reset is the fetch at RESET_PC
        checks++;
        assert (o_sync === 1'b1 && o_rw === 1'b1) else begin
            errors++;
            $display("ERR %0t: first cycle has sync %b rw %b, expected 1 1", $time, o_sync, o_rw);
        end
        check_addr("first fetch address", o_address, RESET_PC);

        for (int k = 0; k < n_records; k++) begin
            while (o_sync !== 1'b1) begin
                @(negedge i_clk);
            end
            rec   = TRACE_BASE + addr_t'(k * RECORD_BYTES);
            fetch = o_address;
            check_addr($sformatf("fetch address of step %0d", k), fetch,
                       {mem[rec + 16'd1], mem[rec]});
            // Previous instruction lands two edges after its successor's sync
            @(negedge i_clk);
            // PC points past the opcode once the fetch cycle is over
            check_addr($sformatf("PC after fetch at %04h", fetch), o_dbg_pc, fetch + 16'd1);
            @(negedge i_clk);
            check_byte($sformatf("AC at %04h", fetch), o_dbg_ac, mem[rec + 16'd2]);
            check_byte($sformatf("X at %04h", fetch), o_dbg_x, mem[rec + 16'd3]);
            check_byte($sformatf("Y at %04h", fetch), o_dbg_y, mem[rec + 16'd4]);
            check_byte($sformatf("P at %04h", fetch), o_dbg_p, mem[rec + 16'd5]);
        end

        check_addr("halt fetch address", fetch, halt_addr);
        check_byte("final AC", o_dbg_ac, mem[SUMMARY_BASE]);
        check_byte("final X", o_dbg_x, mem[SUMMARY_BASE + 16'd1]);
        check_byte("final Y", o_dbg_y, mem[SUMMARY_BASE + 16'd2]);
        check_byte("final P", o_dbg_p, mem[SUMMARY_BASE + 16'd3]);
        check_byte("readback of stored byte", mem[store_addr], store_val);
        checks++;
        assert (writes == 1) else begin
            errors++;
            $display("ERR %0t: %0d write cycles seen, expected 1", $time, writes);
        end

        print_counts();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the halt address was reached",
                 WATCHDOG_CYCLES);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- dv/cpu6502_vectors.hex
// Program at 0200 and 0240; trace at FF00: fetch addr lo hi, then AC X Y P before that fetch
// Summary at FFF0: AC X Y P, store addr lo hi, store value, halt addr lo hi, record count
@0200
A2 FF E8 A0 7F A9 3C AA A8 A2 80 8A 38 69 7F 18
69 C0 69 50 09 0F 29 F3 49 FF 8D 00 03 A9 00 4C 40 02
// Readback, overflow case and halt loop
@0240
AD 00 03 EA 69 01 A9 50 69 50 4C 4A 02
@FF00
00 02 00 00 00 00
02 02 00 FF 00 80
03 02 00 00 00 02
05 02 00 00 7F 00
07 02 3C 00 7F 00
08 02 3C 3C 7F 00
09 02 3C 3C 3C 00
0B 02 3C 80 3C 80
0C 02 80 80 3C 80
0D 02 80 80 3C 81
0F 02 00 80 3C 03
10 02 00 80 3C 02
12 02 C0 80 3C 80
14 02 10 80 3C 01
16 02 1F 80 3C 01
18 02 13 80 3C 01
1A 02 EC 80 3C 81
1D 02 EC 80 3C 81
1F 02 00 80 3C 03
40 02 00 80 3C 03
43 02 EC 80 3C 81
44 02 EC 80 3C 81
46 02 EE 80 3C 80
48 02 50 80 3C 00
4A 02 A0 80 3C C0
@FFF0
A0 80 3C C0 00 03 EC 4A 02 19

//--- vlog.f
verilog/cpu6502_pkg.sv
verilog/cpu_ctrl_if.sv
verilog/timing_control.sv
verilog/decoder.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpu6502.sv
dv/tb_clock.sv
dv/cpu6502_sva.sv
dv/cpu6502_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the cpu6502 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module cpu6502_tb -Mdir "$BUILD" -o cpu6502_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD/cpu6502_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
